// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  # Design sources in compile order
  - files:
      - mem_pkg.sv
      - line_store.sv
      - mem_ctrl.sv
      - mem_arbiter.sv
      - mem_subsys_top.sv

  # Testbench, top module tb_mem_subsys
  - target: test
    files:
      - tb_mem_checker.sv
      - tb_mem_subsys.sv

// ==== files.f ====
mem_pkg.sv
line_store.sv
mem_ctrl.sv
mem_arbiter.sv
mem_subsys_top.sv
tb_mem_checker.sv
tb_mem_subsys.sv

// ==== line_store.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 64 x 512-bit single-port line array
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module line_store (
    input  logic                                clk,
    input  logic [mem_pkg::line_index_bits-1:0] line_addr,
    input  logic                                wr_en,
    input  logic                                rd_en,
    input  logic [mem_pkg::line_width-1:0]      wr_line,
    output logic [mem_pkg::line_width-1:0]      rd_line
);

    logic [mem_pkg::line_width-1:0] lines [mem_pkg::num_lines];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            lines[line_addr] <= wr_line;
        end
    end

    // Registered read, data one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_line <= lines[line_addr];
        end
    end

endmodule

// ==== mem_arbiter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin arbiter for four
// requesters in front of mem_ctrl
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mem_arbiter (
    input  logic                                clk,
    input  logic                                rst_n,
    // Source 1
    input  logic [mem_pkg::op_width-1:0]        op_src1,
    input  logic [mem_pkg::addr_width-1:0]      raw_address_src1,
    input  logic [mem_pkg::line_width-1:0]      common_data_bus_read_in_src1,
    output logic [mem_pkg::line_width-1:0]      common_data_bus_write_out_src1,
    output logic                                tx_done_src1,
    output logic                                rd_valid_src1,
    // Source 2
    input  logic [mem_pkg::op_width-1:0]        op_src2,
    input  logic [mem_pkg::addr_width-1:0]      raw_address_src2,
    input  logic [mem_pkg::line_width-1:0]      common_data_bus_read_in_src2,
    output logic [mem_pkg::line_width-1:0]      common_data_bus_write_out_src2,
    output logic                                tx_done_src2,
    output logic                                rd_valid_src2,
    // Source 3
    input  logic [mem_pkg::op_width-1:0]        op_src3,
    input  logic [mem_pkg::addr_width-1:0]      raw_address_src3,
    input  logic [mem_pkg::line_width-1:0]      common_data_bus_read_in_src3,
    output logic [mem_pkg::line_width-1:0]      common_data_bus_write_out_src3,
    output logic                                tx_done_src3,
    output logic                                rd_valid_src3,
    // Source 4
    input  logic [mem_pkg::op_width-1:0]        op_src4,
    input  logic [mem_pkg::addr_width-1:0]      raw_address_src4,
    input  logic [mem_pkg::line_width-1:0]      common_data_bus_read_in_src4,
    output logic [mem_pkg::line_width-1:0]      common_data_bus_write_out_src4,
    output logic                                tx_done_src4,
    output logic                                rd_valid_src4,
    // Replies from the controller
    input  logic [mem_pkg::line_width-1:0]      common_data_bus_write_out,
    input  logic                                tx_done,
    input  logic                                rd_valid,
    // Request towards the controller
    output logic [mem_pkg::op_width-1:0]        op,
    output logic [mem_pkg::ctrl_addr_width-1:0] raw_address,
    output logic [mem_pkg::line_width-1:0]      common_data_bus_read_in
);

    logic [mem_pkg::sel_width-1:0] sel;
    logic [mem_pkg::sel_width-1:0] sel_next;
    logic                          req_active;

    // Index of the source owning the controller, source 1 is index 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel <= '0;
        end else begin
            sel <= sel_next;
        end
    end

    // Only real reads and writes hold ownership
    assign req_active = (op == mem_pkg::op_read) || (op == mem_pkg::op_write);

    // Stay until the transfer completes, an idle source costs one cycle
    always_comb begin
        if (req_active && !tx_done) begin
            sel_next = sel;
        end else if (sel == mem_pkg::sel_width'(mem_pkg::num_src - 1)) begin
            sel_next = '0;
        end else begin
            sel_next = sel + 1'b1;
        end
    end

    // Request and reply routing, unselected sources see zeros
    always_comb begin
        op                      = mem_pkg::op_idle;
        raw_address             = '0;
        common_data_bus_read_in = '0;

        common_data_bus_write_out_src1 = '0;
        common_data_bus_write_out_src2 = '0;
        common_data_bus_write_out_src3 = '0;
        common_data_bus_write_out_src4 = '0;
        tx_done_src1  = 1'b0;
        tx_done_src2  = 1'b0;
        tx_done_src3  = 1'b0;
        tx_done_src4  = 1'b0;
        rd_valid_src1 = 1'b0;
        rd_valid_src2 = 1'b0;
        rd_valid_src3 = 1'b0;
        rd_valid_src4 = 1'b0;

        case (sel)
            2'd0: begin
                op                             = op_src1;
                raw_address                    = mem_pkg::ctrl_addr_width'(raw_address_src1);
                common_data_bus_read_in        = common_data_bus_read_in_src1;
                common_data_bus_write_out_src1 = common_data_bus_write_out;
                tx_done_src1                   = tx_done;
                rd_valid_src1                  = rd_valid;
            end
            2'd1: begin
                op                             = op_src2;
                raw_address                    = mem_pkg::ctrl_addr_width'(raw_address_src2);
                common_data_bus_read_in        = common_data_bus_read_in_src2;
                common_data_bus_write_out_src2 = common_data_bus_write_out;
                tx_done_src2                   = tx_done;
                rd_valid_src2                  = rd_valid;
            end
            2'd2: begin
                op                             = op_src3;
                raw_address                    = mem_pkg::ctrl_addr_width'(raw_address_src3);
                common_data_bus_read_in        = common_data_bus_read_in_src3;
                common_data_bus_write_out_src3 = common_data_bus_write_out;
                tx_done_src3                   = tx_done;
                rd_valid_src3                  = rd_valid;
            end
            default: begin
                op                             = op_src4;
                raw_address                    = mem_pkg::ctrl_addr_width'(raw_address_src4);
                common_data_bus_read_in        = common_data_bus_read_in_src4;
                common_data_bus_write_out_src4 = common_data_bus_write_out;
                tx_done_src4                   = tx_done;
                rd_valid_src4                  = rd_valid;
            end
        endcase
    end

endmodule

// ==== mem_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed-latency line memory controller
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mem_ctrl (
    input  logic                                  clk,
    input  logic                                  rst_n,
    // Request from the arbiter
    input  logic [mem_pkg::op_width-1:0]          op,
    input  logic [mem_pkg::ctrl_addr_width-1:0]   raw_address,
    input  logic [mem_pkg::line_width-1:0]        common_data_bus_read_in,
    // Reply to the arbiter
    output logic [mem_pkg::line_width-1:0]        common_data_bus_write_out,
    output logic                                  tx_done,
    output logic                                  rd_valid,
    // Line store side
    output logic [mem_pkg::line_index_bits-1:0]   line_addr,
    output logic                                  wr_en,
    output logic                                  rd_en,
    output logic [mem_pkg::line_width-1:0]        wr_line,
    input  logic [mem_pkg::line_width-1:0]        rd_line
);

    typedef enum logic {
        st_idle,
        st_busy
    } state_t;

    state_t                              state;
    logic [mem_pkg::lat_cnt_width-1:0]   cnt;
    logic [mem_pkg::lat_cnt_width-1:0]   target;
    logic                                is_write;
    logic                                accept;
    logic                                done;

    // Code 3 falls through as idle
    assign accept = (state == st_idle) &&
                    ((op == mem_pkg::op_read) || (op == mem_pkg::op_write));

    assign target = is_write ? mem_pkg::lat_cnt_width'(mem_pkg::wr_latency)
                             : mem_pkg::lat_cnt_width'(mem_pkg::rd_latency);

    // Counter reads 1 in the first cycle after acceptance
    assign done = (state == st_busy) && (cnt == target);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            cnt      <= '0;
            is_write <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state    <= st_busy;
                        cnt      <= mem_pkg::lat_cnt_width'(1);
                        is_write <= (op == mem_pkg::op_write);
                    end
                end
                default: begin
                    if (done) begin
                        state <= st_idle;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Request payload, captured once per transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            line_addr <= raw_address[mem_pkg::line_offset_bits +: mem_pkg::line_index_bits];
            wr_line   <= common_data_bus_read_in;
        end
    end

    assign tx_done  = done;
    assign rd_valid = done && !is_write;
    assign wr_en    = done && is_write;

    // Read issued a cycle early so the line is ready with tx_done
    assign rd_en = (state == st_busy) && !is_write && (cnt == target - 1'b1);

    assign common_data_bus_write_out = rd_valid ? rd_line : '0;

endmodule

// ==== mem_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, op codes, latencies
// and line store geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mem_pkg;

    // Bus widths
    localparam int addr_width      = 32;
    localparam int ctrl_addr_width = 64;
    localparam int line_width      = 512;
    localparam int op_width        = 2;

    // Operation codes, code 3 is unused and acts as idle
    localparam logic [op_width-1:0] op_idle  = 2'd0;
    localparam logic [op_width-1:0] op_read  = 2'd1;
    localparam logic [op_width-1:0] op_write = 2'd2;

    // Requesters sharing the controller
    localparam int num_src   = 4;
    localparam int sel_width = $clog2(num_src);

    // Store geometry, 64-byte lines
    localparam int line_offset_bits = 6;
    localparam int line_index_bits  = 6;
    localparam int num_lines        = 2 ** line_index_bits;

    // Fixed service times in cycles after acceptance
    localparam int rd_latency = 4;
    localparam int wr_latency = 3;

    localparam int max_latency   = (rd_latency > wr_latency) ? rd_latency : wr_latency;
    localparam int lat_cnt_width = $clog2(max_latency + 1);

endpackage

// ==== mem_subsys_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Line memory subsystem top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module mem_subsys_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [mem_pkg::op_width-1:0]   op_src1,
    input  logic [mem_pkg::addr_width-1:0] raw_address_src1,
    input  logic [mem_pkg::line_width-1:0] common_data_bus_read_in_src1,
    output logic [mem_pkg::line_width-1:0] common_data_bus_write_out_src1,
    output logic                           tx_done_src1,
    output logic                           rd_valid_src1,
    input  logic [mem_pkg::op_width-1:0]   op_src2,
    input  logic [mem_pkg::addr_width-1:0] raw_address_src2,
    input  logic [mem_pkg::line_width-1:0] common_data_bus_read_in_src2,
    output logic [mem_pkg::line_width-1:0] common_data_bus_write_out_src2,
    output logic                           tx_done_src2,
    output logic                           rd_valid_src2,
    input  logic [mem_pkg::op_width-1:0]   op_src3,
    input  logic [mem_pkg::addr_width-1:0] raw_address_src3,
    input  logic [mem_pkg::line_width-1:0] common_data_bus_read_in_src3,
    output logic [mem_pkg::line_width-1:0] common_data_bus_write_out_src3,
    output logic                           tx_done_src3,
    output logic                           rd_valid_src3,
    input  logic [mem_pkg::op_width-1:0]   op_src4,
    input  logic [mem_pkg::addr_width-1:0] raw_address_src4,
    input  logic [mem_pkg::line_width-1:0] common_data_bus_read_in_src4,
    output logic [mem_pkg::line_width-1:0] common_data_bus_write_out_src4,
    output logic                           tx_done_src4,
    output logic                           rd_valid_src4
);

    // Arbiter to controller
    logic [mem_pkg::op_width-1:0]        op;
    logic [mem_pkg::ctrl_addr_width-1:0] raw_address;
    logic [mem_pkg::line_width-1:0]      common_data_bus_read_in;
    logic [mem_pkg::line_width-1:0]      common_data_bus_write_out;
    logic                                tx_done;
    logic                                rd_valid;

    // Controller to line store
    logic [mem_pkg::line_index_bits-1:0] line_addr;
    logic                                wr_en;
    logic                                rd_en;
    logic [mem_pkg::line_width-1:0]      wr_line;
    logic [mem_pkg::line_width-1:0]      rd_line;

    mem_arbiter i_mem_arbiter (
        .clk                            (clk),
        .rst_n                          (rst_n),
        .op_src1                        (op_src1),
        .raw_address_src1               (raw_address_src1),
        .common_data_bus_read_in_src1   (common_data_bus_read_in_src1),
        .common_data_bus_write_out_src1 (common_data_bus_write_out_src1),
        .tx_done_src1                   (tx_done_src1),
        .rd_valid_src1                  (rd_valid_src1),
        .op_src2                        (op_src2),
        .raw_address_src2               (raw_address_src2),
        .common_data_bus_read_in_src2   (common_data_bus_read_in_src2),
        .common_data_bus_write_out_src2 (common_data_bus_write_out_src2),
        .tx_done_src2                   (tx_done_src2),
        .rd_valid_src2                  (rd_valid_src2),
        .op_src3                        (op_src3),
        .raw_address_src3               (raw_address_src3),
        .common_data_bus_read_in_src3   (common_data_bus_read_in_src3),
        .common_data_bus_write_out_src3 (common_data_bus_write_out_src3),
        .tx_done_src3                   (tx_done_src3),
        .rd_valid_src3                  (rd_valid_src3),
        .op_src4                        (op_src4),
        .raw_address_src4               (raw_address_src4),
        .common_data_bus_read_in_src4   (common_data_bus_read_in_src4),
        .common_data_bus_write_out_src4 (common_data_bus_write_out_src4),
        .tx_done_src4                   (tx_done_src4),
        .rd_valid_src4                  (rd_valid_src4),
        .common_data_bus_write_out      (common_data_bus_write_out),
        .tx_done                        (tx_done),
        .rd_valid                       (rd_valid),
        .op                             (op),
        .raw_address                    (raw_address),
        .common_data_bus_read_in        (common_data_bus_read_in)
    );

    mem_ctrl i_mem_ctrl (
        .clk                       (clk),
        .rst_n                     (rst_n),
        .op                        (op),
        .raw_address               (raw_address),
        .common_data_bus_read_in   (common_data_bus_read_in),
        .common_data_bus_write_out (common_data_bus_write_out),
        .tx_done                   (tx_done),
        .rd_valid                  (rd_valid),
        .line_addr                 (line_addr),
        .wr_en                     (wr_en),
        .rd_en                     (rd_en),
        .wr_line                   (wr_line),
        .rd_line                   (rd_line)
    );

    line_store i_line_store (
        .clk       (clk),
        .line_addr (line_addr),
        .wr_en     (wr_en),
        .rd_en     (rd_en),
        .wr_line   (wr_line),
        .rd_line   (rd_line)
    );

endmodule

// ==== tb_mem_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Checker with reference line model,
// handshake and round-robin checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_mem_checker (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic [mem_pkg::num_src-1:0][mem_pkg::op_width-1:0]   op,
    input  logic [mem_pkg::num_src-1:0][mem_pkg::addr_width-1:0] addr,
    input  logic [mem_pkg::num_src-1:0][mem_pkg::line_width-1:0] wdata,
    input  logic [mem_pkg::num_src-1:0][mem_pkg::line_width-1:0] rdata,
    input  logic [mem_pkg::num_src-1:0]                          tx_done,
    input  logic [mem_pkg::num_src-1:0]                          rd_valid,
    output int                                                   err_count,
    output int                                                   txn_count
);

    logic [mem_pkg::line_width-1:0] model [mem_pkg::num_lines];
    logic                           line_valid [mem_pkg::num_lines];
    int                             held [mem_pkg::num_src];
    logic [mem_pkg::num_src-1:0]    prev_done;
    // Bit s set in seen[k] when s completed while k was waiting
    logic [mem_pkg::num_src-1:0]    seen [mem_pkg::num_src];
    // Source of the most recent completion
    int                             last_src;

    // 64-byte lines, 64 of them, so the index wraps every 4 KiB
    function automatic int line_index_of(input logic [mem_pkg::addr_width-1:0] a);
        return (a / 64) % mem_pkg::num_lines;
    endfunction

    function automatic logic is_active(input logic [mem_pkg::op_width-1:0] o);
        return (o == mem_pkg::op_read) || (o == mem_pkg::op_write);
    endfunction

    task automatic report_err(input int s, input string msg);
        err_count++;
        $display("ERR %0t: source %0d, %s", $time, s + 1, msg);
    endtask

    task automatic check_source(input int s);
        int idx;
        int lat;
        int gap_s;
        idx = line_index_of(addr[s]);
        lat = (op[s] == mem_pkg::op_write) ? mem_pkg::wr_latency : mem_pkg::rd_latency;
        // Steps from the previous completer to this one, 1 to num_src
        gap_s = (s - last_src + mem_pkg::num_src - 1) % mem_pkg::num_src + 1;
        if (rd_valid[s] && !tx_done[s])
            report_err(s, "rd_valid without tx_done");
        if (!rd_valid[s] && rdata[s] != '0)
            report_err(s, "read data not zero outside rd_valid");
        if (tx_done[s]) begin
            txn_count++;
            if (prev_done[s])
                report_err(s, "tx_done longer than one cycle");
            if (!is_active(op[s])) begin
                report_err(s, "tx_done while op is idle");
            end else begin
                if (rd_valid[s] != (op[s] == mem_pkg::op_read))
                    report_err(s, "rd_valid does not match op");
                if (held[s] < lat)
                    report_err(s, $sformatf("done after %0d cycles, latency %0d", held[s], lat));
                for (int k = 0; k < mem_pkg::num_src; k++) begin
                    if (k != s && is_active(op[k]) && seen[k][s])
                        report_err(k, $sformatf("waiting while source %0d completed twice", s + 1));
                    // Waiting since the last completion and earlier in the rotation than s
                    if (k != s && is_active(op[k]) && seen[k][last_src]
                            && (k - last_src + mem_pkg::num_src) % mem_pkg::num_src < gap_s)
                        report_err(k, $sformatf("passed over before source %0d completed",
                                                s + 1));
                end
                if (op[s] == mem_pkg::op_write) begin
                    model[idx]      = wdata[s];
                    line_valid[idx] = 1'b1;
                end else if (line_valid[idx] && rdata[s] !== model[idx]) begin
                    report_err(s, $sformatf("read of line %0d does not match model", idx));
                end
            end
        end
    endtask

    task automatic update_tracking();
        for (int s = 0; s < mem_pkg::num_src; s++) begin
            for (int k = 0; k < mem_pkg::num_src; k++) begin
                if (tx_done[s] && k != s && is_active(op[k]))
                    seen[k][s] = 1'b1;
            end
        end
        for (int s = 0; s < mem_pkg::num_src; s++) begin
            if (tx_done[s])
                last_src = s;
            if (!is_active(op[s]) || tx_done[s]) begin
                seen[s] = '0;
                held[s] = 0;
            end else begin
                held[s]++;
            end
        end
        prev_done = tx_done;
    endtask

    initial begin
        err_count = 0;
        txn_count = 0;
        prev_done = '0;
        last_src  = mem_pkg::num_src - 1;
        for (int i = 0; i < mem_pkg::num_lines; i++)
            line_valid[i] = 1'b0;
        for (int s = 0; s < mem_pkg::num_src; s++) begin
            held[s] = 0;
            seen[s] = '0;
        end
    end

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            if (tx_done != '0 || rd_valid != '0) begin
                err_count++;
                $display("ERR %0t: reply outputs active during reset", $time);
            end
        end else begin
            if ((tx_done & (tx_done - 1'b1)) != '0) begin
                err_count++;
                $display("ERR %0t: tx_done seen by more than one source", $time);
            end
            for (int s = 0; s < mem_pkg::num_src; s++)
                check_source(s);
            update_tracking();
        end
    end

endmodule

// ==== tb_mem_subsys.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench top with four requesters,
// watchdog and closing report
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_mem_subsys;

    localparam int clk_period  = 4;
    localparam int n_lines_src = mem_pkg::num_lines / mem_pkg::num_src;
    localparam int n_random    = 400;
    localparam int txn_per_src = 2 * n_lines_src + n_random;
    localparam int total_txn   = mem_pkg::num_src * txn_per_src;
    localparam int watchdog_cycles =
        total_txn * (mem_pkg::max_latency + mem_pkg::num_src + 4) + 1000;

    logic clk;
    logic rst_n      = 1'b0;
    logic stim_ready = 1'b0;
    int   err_count;
    int   txn_count;
    int   tb_errors  = 0;

    wire [mem_pkg::num_src-1:0][mem_pkg::op_width-1:0]   op_bus;
    wire [mem_pkg::num_src-1:0][mem_pkg::addr_width-1:0] addr_bus;
    wire [mem_pkg::num_src-1:0][mem_pkg::line_width-1:0] wdata_bus;
    wire [mem_pkg::num_src-1:0][mem_pkg::line_width-1:0] rdata_bus;
    wire [mem_pkg::num_src-1:0]                          tx_done_bus;
    wire [mem_pkg::num_src-1:0]                          rd_valid_bus;
    wire [mem_pkg::num_src-1:0]                          wr_done_bus;
    wire [mem_pkg::num_src-1:0]                          finished_bus;

    // Random phase stimulus, filled once before the requesters start
    logic [mem_pkg::op_width-1:0]   rnd_op   [mem_pkg::num_src][n_random];
    logic [mem_pkg::addr_width-1:0] rnd_addr [mem_pkg::num_src][n_random];
    logic [31:0]                    rnd_word [mem_pkg::num_src][n_random];
    int                             rnd_gap  [mem_pkg::num_src][n_random];

    // Spreads one word over a whole line, each 32-bit lane different
    function automatic logic [mem_pkg::line_width-1:0] make_line(input logic [31:0] seed);
        logic [mem_pkg::line_width-1:0] line;
        for (int i = 0; i < mem_pkg::line_width / 32; i++)
            line[i*32 +: 32] = seed ^ (32'h9e37_79b9 * 32'(i + 1));
        return line;
    endfunction

    mem_subsys_top i_mem_subsys_top (
        .clk                            (clk),
        .rst_n                          (rst_n),
        .op_src1                        (op_bus[0]),
        .raw_address_src1               (addr_bus[0]),
        .common_data_bus_read_in_src1   (wdata_bus[0]),
        .common_data_bus_write_out_src1 (rdata_bus[0]),
        .tx_done_src1                   (tx_done_bus[0]),
        .rd_valid_src1                  (rd_valid_bus[0]),
        .op_src2                        (op_bus[1]),
        .raw_address_src2               (addr_bus[1]),
        .common_data_bus_read_in_src2   (wdata_bus[1]),
        .common_data_bus_write_out_src2 (rdata_bus[1]),
        .tx_done_src2                   (tx_done_bus[1]),
        .rd_valid_src2                  (rd_valid_bus[1]),
        .op_src3                        (op_bus[2]),
        .raw_address_src3               (addr_bus[2]),
        .common_data_bus_read_in_src3   (wdata_bus[2]),
        .common_data_bus_write_out_src3 (rdata_bus[2]),
        .tx_done_src3                   (tx_done_bus[2]),
        .rd_valid_src3                  (rd_valid_bus[2]),
        .op_src4                        (op_bus[3]),
        .raw_address_src4               (addr_bus[3]),
        .common_data_bus_read_in_src4   (wdata_bus[3]),
        .common_data_bus_write_out_src4 (rdata_bus[3]),
        .tx_done_src4                   (tx_done_bus[3]),
        .rd_valid_src4                  (rd_valid_bus[3])
    );

    tb_mem_checker i_tb_mem_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .op        (op_bus),
        .addr      (addr_bus),
        .wdata     (wdata_bus),
        .rdata     (rdata_bus),
        .tx_done   (tx_done_bus),
        .rd_valid  (rd_valid_bus),
        .err_count (err_count),
        .txn_count (txn_count)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    end

    initial begin
        void'($urandom(82));
        for (int s = 0; s < mem_pkg::num_src; s++) begin
            for (int k = 0; k < n_random; k++) begin
                rnd_op[s][k]   = ($urandom % 2) ? mem_pkg::op_write : mem_pkg::op_read;
                rnd_addr[s][k] = $urandom;
                rnd_word[s][k] = $urandom;
                rnd_gap[s][k]  = $urandom % 4;
            end
        end
        stim_ready = 1'b1;
    end

    for (genvar g = 0; g < mem_pkg::num_src; g++) begin : g_req
        logic [mem_pkg::op_width-1:0]   op_r     = mem_pkg::op_idle;
        logic [mem_pkg::addr_width-1:0] addr_r   = '0;
        logic [mem_pkg::line_width-1:0] data_r   = '0;
        logic                           wr_done  = 1'b0;
        logic                           finished = 1'b0;

        assign op_bus[g]       = op_r;
        assign addr_bus[g]     = addr_r;
        assign wdata_bus[g]    = data_r;
        assign wr_done_bus[g]  = wr_done;
        assign finished_bus[g] = finished;

        // Hold the request until tx_done, then one idle cycle
        task automatic do_request(input logic [mem_pkg::op_width-1:0] o,
                                  input logic [mem_pkg::addr_width-1:0] a,
                                  input logic [mem_pkg::line_width-1:0] d);
            @(posedge clk);
            op_r   <= o;
            addr_r <= a;
            data_r <= d;
            do @(negedge clk); while (!tx_done_bus[g]);
            @(posedge clk);
            op_r <= mem_pkg::op_idle;
        endtask

        initial begin
            logic [mem_pkg::line_index_bits-1:0] idx;
            wait (rst_n === 1'b1 && stim_ready);
            // Every fourth line belongs to this source, upper 20 bits vary
            for (int i = 0; i < n_lines_src; i++) begin
                idx = mem_pkg::line_index_bits'(i * mem_pkg::num_src + g);
                do_request(mem_pkg::op_write, {20'(g * 16 + i), idx, 6'(3 * i)},
                           make_line(32'hc0de_0000 | 32'(idx)));
            end
            wr_done <= 1'b1;
            wait (&wr_done_bus);
            // Read lines written two sources away, through aliased addresses
            for (int i = 0; i < n_lines_src; i++) begin
                idx = mem_pkg::line_index_bits'(i * mem_pkg::num_src
                                                + (g + 2) % mem_pkg::num_src);
                do_request(mem_pkg::op_read, {20'hfffff - 20'(i), idx, 6'(63 - i)}, '0);
            end
            for (int k = 0; k < n_random; k++) begin
                repeat (rnd_gap[g][k]) @(posedge clk);
                do_request(rnd_op[g][k], rnd_addr[g][k], make_line(rnd_word[g][k]));
            end
            finished <= 1'b1;
        end
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired after %0d cycles with requests still open",
                 watchdog_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        wait (&finished_bus);
        repeat (10) @(posedge clk);
        if (txn_count != total_txn) begin
            $display("Checker counted %0d completions but %0d requests were issued",
                     txn_count, total_txn);
            tb_errors++;
        end
        $display("Closing report: %0d errors, %0d transactions",
                 err_count + tb_errors, txn_count);
        if (err_count + tb_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
